// File: common/pb_defs.svh
`ifndef PB_DEFS_SVH
`define PB_DEFS_SVH

////////////////////////////////////////////////////////////////////////////
// Bus timing
////////////////////////////////////////////////////////////////////////////
`define PB_WAIT_UNIT_CYCLES 22      // One ~750 ns wait unit
`define PB_INIT_CYCLES      100     // Power-up hold of lamp reset

////////////////////////////////////////////////////////////////////////////
// Command layout
////////////////////////////////////////////////////////////////////////////
`define PB_NUM_CARDS        4       // Cards on the phase bus
`define PB_KEYWORD_LEN      11      // Keyword incl. trailing comma
`define PB_NUM_PARAMS       5       // Port byte plus one byte per card
`define PB_BUF_DEPTH        32      // Sentence buffer, extra bytes dropped

////////////////////////////////////////////////////////////////////////////
// Reply text
////////////////////////////////////////////////////////////////////////////
`define PB_FAIL_CODE        8'h54   // Code shown in "Failed 0x.."
`define PB_CHAR_LF          8'h0A
`define PB_CHAR_CR          8'h0D

`endif

// File: common/pb_pkg.sv
`include "pb_defs.svh"

package pb_pkg;

    // Commands accepted by the parser
    typedef enum logic [1:0] {
        CMD_WRITE4 = 2'd0,                          // "pb_i_write,"
        CMD_READ4  = 2'd1                           // "pb_i__read,"
    } pb_cmd_t;

    // Phase bus pins, the data pad itself lives outside
    typedef struct packed {
        logic [`PB_NUM_CARDS-1:0] card_sel;         // One-hot card select, zero when idle
        logic [2:0]               port_addr;        // Port address on the card
        logic                     rd_n;             // Read enable, active low
        logic                     wr_n;             // Write strobe, active low
        logic [7:0]               data_out;         // Byte toward the cards
        logic                     data_oe;          // Pad drive enable
    } pb_bus_t;

    // Decoded sentence handed to the sequencer
    typedef struct packed {
        pb_cmd_t                       cmd;
        logic [7:0]                    port;        // Parameter byte 0
        logic [`PB_NUM_CARDS-1:0][7:0] data;        // data[k] goes to card k
    } pb_request_t;

    // Finished command handed to the formatter
    typedef struct packed {
        pb_cmd_t                       cmd;
        logic [7:0]                    port;
        logic [`PB_NUM_CARDS-1:0][7:0] rd_data;     // rd_data[k] read from card k
    } pb_result_t;

endpackage

// File: logic/command_parser.sv
`include "pb_defs.svh"

module command_parser (
    input  logic                clock,
    input  logic                arst_n,
    input  logic [7:0]          rx_data,
    input  logic                rx_valid,
    input  logic                op_done,
    output logic                req_start,
    output pb_pkg::pb_request_t req,
    output logic                parse_fail
);

    localparam int ADDR_W = $clog2(`PB_BUF_DEPTH);
    localparam int KW_BITS = 8 * `PB_KEYWORD_LEN;

    typedef enum logic [1:0] {
        P_COLLECT,                                  // Storing sentence bytes
        P_DECODE,                                   // Line feed seen, judge keyword
        P_WAIT_DONE                                 // Request running on the bus
    } parse_state_t;

    parse_state_t state;

    logic [7:0]      line_buf [`PB_BUF_DEPTH];
    logic [ADDR_W:0] wr_idx;                        // Also the sentence length
    logic            store_byte;

    logic [KW_BITS-1:0]               kw_word;
    logic [`PB_NUM_PARAMS-1:0][7:0]   params;
    logic                             kw_write;
    logic                             kw_read;

    // Either case accepted, anything else reads as F
    function automatic logic [3:0] hex_nibble(input logic [7:0] c);
        if (c >= "0" && c <= "9") begin
            return 4'(c - "0");
        end else if (c >= "a" && c <= "f") begin
            return 4'(c - "a" + 8'd10);
        end else if (c >= "A" && c <= "F") begin
            return 4'(c - "A" + 8'd10);
        end
        return 4'hF;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Sentence buffer
    ////////////////////////////////////////////////////////////////////////////
    assign store_byte = (state == P_COLLECT) && rx_valid && (rx_data != `PB_CHAR_LF)
                        && (wr_idx < `PB_BUF_DEPTH);

    always_ff @(posedge clock) begin
        if (store_byte) begin
            line_buf[wr_idx[ADDR_W-1:0]] <= rx_data;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Keyword match and hex decode
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        logic [7:0] hi_c;
        logic [7:0] lo_c;
        kw_word = '0;
        for (int i = 0; i < `PB_KEYWORD_LEN; i++) begin
            kw_word = {kw_word[KW_BITS-9:0], line_buf[i]};  // First char ends up on top
        end
        for (int p = 0; p < `PB_NUM_PARAMS; p++) begin
            // Characters past the line end are stale, treat as non-hex
            hi_c = (`PB_KEYWORD_LEN + 2 * p < wr_idx) ? line_buf[`PB_KEYWORD_LEN + 2 * p]
                                                      : 8'h00;
            lo_c = (`PB_KEYWORD_LEN + 2 * p + 1 < wr_idx)
                   ? line_buf[`PB_KEYWORD_LEN + 2 * p + 1] : 8'h00;
            params[p] = {hex_nibble(hi_c), hex_nibble(lo_c)};
        end
    end

    assign kw_write = (wr_idx >= `PB_KEYWORD_LEN) && (kw_word == "pb_i_write,");
    assign kw_read  = (wr_idx >= `PB_KEYWORD_LEN) && (kw_word == "pb_i__read,");

    ////////////////////////////////////////////////////////////////////////////
    // Control
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state      <= P_COLLECT;
            wr_idx     <= '0;
            req_start  <= 1'b0;
            parse_fail <= 1'b0;
        end else begin
            req_start  <= 1'b0;                     // Both are single-cycle strobes
            parse_fail <= 1'b0;
            case (state)
                P_COLLECT: begin
                    if (rx_valid && rx_data == `PB_CHAR_LF) begin
                        state <= P_DECODE;
                    end else if (store_byte) begin
                        wr_idx <= wr_idx + 1'b1;
                    end
                end
                P_DECODE: begin
                    wr_idx <= '0;                   // Next sentence starts at 0
                    if (kw_write || kw_read) begin
                        req_start <= 1'b1;
                        state     <= P_WAIT_DONE;
                    end else begin
                        parse_fail <= 1'b1;
                        state      <= P_COLLECT;
                    end
                end
                P_WAIT_DONE: begin
                    if (op_done) begin              // Incoming bytes ignored till here
                        state <= P_COLLECT;
                    end
                end
                default: state <= P_COLLECT;
            endcase
        end
    end

    // Request payload, valid with req_start
    always_ff @(posedge clock) begin
        if (state == P_DECODE) begin
            req.cmd  <= kw_read ? pb_pkg::CMD_READ4 : pb_pkg::CMD_WRITE4;
            req.port <= params[0];
            for (int k = 0; k < `PB_NUM_CARDS; k++) begin
                req.data[k] <= params[k + 1];       // Byte 0 is the port
            end
        end
    end

endmodule

// File: phase_bus/phase_bus_sequencer.sv
`include "pb_defs.svh"

module phase_bus_sequencer (
    input  logic                clock,
    input  logic                arst_n,
    input  logic                req_start,
    input  pb_pkg::pb_request_t req,
    input  logic [7:0]          data_in,
    output pb_pkg::pb_bus_t     bus,
    output logic                lamp_reset,
    output logic                shifter_oe,
    output logic                op_done,
    output pb_pkg::pb_result_t  result
);

    localparam int UNIT_W = $clog2(`PB_WAIT_UNIT_CYCLES);
    localparam int INIT_W = $clog2(`PB_INIT_CYCLES);
    localparam int CARD_W = $clog2(`PB_NUM_CARDS);

    typedef enum logic [3:0] {
        S_INIT,                                     // Power-up hold
        S_IDLE,
        S_WAIT,                                     // Count wait units, then after_wait
        S_W_SELECT,
        S_W_DATA,
        S_W_STROBE,
        S_W_RELEASE,
        S_W_DROP,
        S_R_SELECT,
        S_R_SAMPLE,
        S_NEXT,                                     // Advance to next card or finish
        S_DONE
    } seq_state_t;

    seq_state_t state;
    seq_state_t after_wait;

    logic [INIT_W-1:0]   init_cnt;
    logic [UNIT_W-1:0]   unit_cnt;                  // Cycles within one unit
    logic [2:0]          units_left;
    logic [CARD_W-1:0]   card_idx;
    logic                pend;                      // Request waiting to start
    pb_pkg::pb_request_t req_q;

    task automatic start_wait(input logic [2:0] units, input seq_state_t nxt);
        units_left <= units;
        after_wait <= nxt;
        state      <= S_WAIT;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Bus FSM
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state      <= S_INIT;
            after_wait <= S_IDLE;
            init_cnt   <= '0;
            unit_cnt   <= '0;
            units_left <= '0;
            card_idx   <= '0;
            pend       <= 1'b0;
            op_done    <= 1'b0;
            lamp_reset <= 1'b1;                     // Lamps held in reset
            shifter_oe <= 1'b0;                     // Level shifter off
            bus        <= '{card_sel: '0, port_addr: '0, rd_n: 1'b1, wr_n: 1'b1,
                            data_out: '0, data_oe: 1'b0};
        end else begin
            op_done <= 1'b0;
            case (state)
                S_INIT: begin
                    if (init_cnt == INIT_W'(`PB_INIT_CYCLES - 1)) begin
                        lamp_reset <= 1'b0;
                        shifter_oe <= 1'b1;
                        state      <= S_IDLE;
                    end else begin
                        init_cnt <= init_cnt + 1'b1;
                    end
                end
                S_IDLE: begin
                    if (pend) begin
                        pend     <= 1'b0;
                        card_idx <= '0;
                        if (req_q.cmd == pb_pkg::CMD_READ4) begin
                            state <= S_R_SELECT;
                        end else begin
                            start_wait(3'd1, S_W_SELECT);   // Pre-delay unit
                        end
                    end
                end
                S_WAIT: begin
                    if (units_left == '0) begin
                        state <= after_wait;
                    end else if (unit_cnt == UNIT_W'(`PB_WAIT_UNIT_CYCLES - 1)) begin
                        unit_cnt   <= '0;
                        units_left <= units_left - 1'b1;
                    end else begin
                        unit_cnt <= unit_cnt + 1'b1;
                    end
                end
                S_W_SELECT: begin
                    bus.card_sel  <= `PB_NUM_CARDS'(1) << card_idx;
                    bus.port_addr <= req_q.port[2:0];  // Low 3 bits only
                    bus.rd_n      <= 1'b1;
                    bus.wr_n      <= 1'b1;
                    start_wait(3'd4, S_W_DATA);
                end
                S_W_DATA: begin
                    bus.data_out <= req_q.data[card_idx];
                    bus.data_oe  <= 1'b1;
                    start_wait(3'd1, S_W_STROBE);
                end
                S_W_STROBE: begin
                    bus.wr_n <= 1'b0;
                    start_wait(3'd2, S_W_RELEASE);
                end
                S_W_RELEASE: begin
                    bus.wr_n <= 1'b1;               // Card latches on this edge
                    start_wait(3'd2, S_W_DROP);
                end
                S_W_DROP: begin
                    bus.data_oe <= 1'b0;
                    start_wait(3'd1, S_NEXT);
                end
                S_R_SELECT: begin
                    bus.card_sel  <= `PB_NUM_CARDS'(1) << card_idx;
                    bus.port_addr <= req_q.port[2:0];
                    bus.rd_n      <= 1'b0;
                    start_wait(3'd1, S_R_SAMPLE);
                end
                S_R_SAMPLE: begin
                    bus.rd_n <= 1'b1;               // Byte captured below
                    start_wait(3'd1, S_NEXT);
                end
                S_NEXT: begin
                    if (card_idx == CARD_W'(`PB_NUM_CARDS - 1)) begin
                        bus.card_sel <= '0;         // Deselect one cycle ahead of op_done
                        state        <= S_DONE;
                    end else begin
                        card_idx <= card_idx + 1'b1;
                        state    <= (req_q.cmd == pb_pkg::CMD_READ4) ? S_R_SELECT
                                                                     : S_W_SELECT;
                    end
                end
                S_DONE: begin
                    op_done <= 1'b1;
                    state   <= S_IDLE;
                end
                default: state <= S_IDLE;
            endcase
            if (req_start) begin                    // Kept through the power-up hold
                pend <= 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Request and result payload
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clock) begin
        if (req_start) begin
            req_q <= req;
        end
        if (state == S_IDLE && pend) begin
            result.cmd  <= req_q.cmd;
            result.port <= req_q.port;
        end
        if (state == S_R_SAMPLE) begin
            result.rd_data[card_idx] <= data_in;
        end
    end

endmodule

// File: logic/reply_formatter.sv
`include "pb_defs.svh"

module reply_formatter (
    input  logic               clock,
    input  logic               arst_n,
    input  logic               parse_fail,
    input  logic               op_done,
    input  pb_pkg::pb_result_t result,
    output logic [7:0]         tx_data,
    output logic               tx_write
);

    localparam int MSG_BYTES = 18;                  // Longest reply, the read one
    localparam int MSG_BITS  = 8 * MSG_BYTES;

    logic [MSG_BITS-1:0] text_word;                 // Reply left-justified, first char on top
    logic [4:0]          text_len;
    logic [MSG_BITS-1:0] msg_word;
    logic [4:0]          left;                      // Bytes still to send
    logic                busy;
    logic                load;
    logic                shift;

    // Upper-case ASCII, 0x37 + 10 is 'A'
    function automatic logic [7:0] hex_char(input logic [3:0] n);
        return (n < 4'd10) ? {4'h3, n} : 8'h37 + {4'h0, n};
    endfunction

    function automatic logic [15:0] hex_pair(input logic [7:0] b);
        return {hex_char(b[7:4]), hex_char(b[3:0])};
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Message text
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        if (parse_fail) begin
            text_word = {"Failed 0x", hex_pair(`PB_FAIL_CODE), `PB_CHAR_CR, `PB_CHAR_LF, 40'h0};
            text_len  = 5'd13;
        end else if (result.cmd == pb_pkg::CMD_READ4) begin
            text_word = {"Read4 0x", hex_pair(result.rd_data[0]), hex_pair(result.rd_data[1]),
                         hex_pair(result.rd_data[2]), hex_pair(result.rd_data[3]),
                         `PB_CHAR_CR, `PB_CHAR_LF};
            text_len  = 5'd18;
        end else begin
            text_word = {"Write 0x", hex_pair(result.port), `PB_CHAR_CR, `PB_CHAR_LF, 48'h0};
            text_len  = 5'd12;
        end
    end

    assign load  = !busy && (parse_fail || op_done);        // Strobes while busy are lost
    assign shift = busy && !tx_write && (left != '0);       // Every second cycle

    ////////////////////////////////////////////////////////////////////////////
    // Byte stepping
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            busy     <= 1'b0;
            tx_write <= 1'b0;
            left     <= '0;
        end else begin
            tx_write <= 1'b0;
            if (load) begin
                busy     <= 1'b1;
                tx_write <= 1'b1;                   // First char right after trigger
                left     <= text_len - 1'b1;
            end else if (shift) begin
                tx_write <= 1'b1;
                left     <= left - 1'b1;
            end else if (busy && !tx_write) begin
                busy <= 1'b0;                       // Last byte went out
            end
        end
    end

    always_ff @(posedge clock) begin
        if (load) begin
            tx_data  <= text_word[MSG_BITS-1 -: 8];
            msg_word <= text_word << 8;
        end else if (shift) begin
            tx_data  <= msg_word[MSG_BITS-1 -: 8];
            msg_word <= msg_word << 8;
        end
    end

endmodule

// File: logic/pb_controller_top.sv
module pb_controller_top (
    input  logic            clock,
    input  logic            arst_n,
    input  logic [7:0]      rx_data,
    input  logic            rx_valid,
    input  logic [7:0]      data_in,
    output pb_pkg::pb_bus_t bus,
    output logic            lamp_reset,
    output logic            shifter_oe,
    output logic [7:0]      tx_data,
    output logic            tx_write
);

    pb_pkg::pb_request_t req;
    pb_pkg::pb_result_t  result;
    logic                req_start;
    logic                parse_fail;
    logic                op_done;

    command_parser i_command_parser (
        .clock      (clock),
        .arst_n     (arst_n),
        .rx_data    (rx_data),
        .rx_valid   (rx_valid),
        .op_done    (op_done),
        .req_start  (req_start),
        .req        (req),
        .parse_fail (parse_fail)
    );

    phase_bus_sequencer i_phase_bus_sequencer (
        .clock      (clock),
        .arst_n     (arst_n),
        .req_start  (req_start),
        .req        (req),
        .data_in    (data_in),
        .bus        (bus),
        .lamp_reset (lamp_reset),
        .shifter_oe (shifter_oe),
        .op_done    (op_done),
        .result     (result)
    );

    reply_formatter i_reply_formatter (
        .clock      (clock),
        .arst_n     (arst_n),
        .parse_fail (parse_fail),
        .op_done    (op_done),
        .result     (result),
        .tx_data    (tx_data),
        .tx_write   (tx_write)
    );

endmodule

// File: dv/pb_bus_checker.sv
`include "pb_defs.svh"

module pb_bus_checker (
    input logic            clock,
    input logic            arst_n,
    input pb_pkg::pb_bus_t bus
);

    int unsigned wr_low_cycles;                     // Length of the current wr_n low period
    int          fail_count = 0;                    // Failed assertions so far

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            wr_low_cycles <= 0;
        end else if (!bus.wr_n) begin
            wr_low_cycles <= wr_low_cycles + 1;
        end else begin
            wr_low_cycles <= 0;                     // Restart on every high cycle
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Bus rules
    ////////////////////////////////////////////////////////////////////////////
    rd_wr_exclusive: assert property (@(posedge clock) disable iff (!arst_n)
        !(!bus.rd_n && !bus.wr_n))
        else begin
            fail_count++;
            $error("rd_n and wr_n are low at the same time");
        end

    data_during_write: assert property (@(posedge clock) disable iff (!arst_n)
        !bus.wr_n |-> bus.data_oe)
        else begin
            fail_count++;
            $error("data_oe is low while wr_n is low");
        end

    card_sel_onehot: assert property (@(posedge clock) disable iff (!arst_n)
        $onehot0(bus.card_sel))
        else begin
            fail_count++;
            $error("more than one card is selected");
        end

    // Counter holds the number of low samples on the first high one
    wr_low_length: assert property (@(posedge clock) disable iff (!arst_n)
        $rose(bus.wr_n) |-> (wr_low_cycles >= 2 * `PB_WAIT_UNIT_CYCLES))
        else begin
            fail_count++;
            $error("wr_n low period is shorter than two wait units");
        end

endmodule

// File: dv/pb_controller_tb.sv
`include "pb_defs.svh"

module pb_controller_tb;

    localparam int ROW_CYCLES   = 1500;             // Cycle bound per table row
    localparam int KIND_WRITE   = 0;
    localparam int KIND_READ    = 1;
    localparam int KIND_REJECT  = 2;                // Unknown keyword, no bus activity

    logic            clock = 1'b0;
    logic            arst_n;
    logic [7:0]      rx_data;
    logic            rx_valid;
    logic [7:0]      data_in;
    pb_pkg::pb_bus_t bus;
    logic            lamp_reset;
    logic            shifter_oe;
    logic [7:0]      tx_data;
    logic            tx_write;

    // Stimulus table, one entry per row in every queue
    string       row_name[$];
    string       row_sentence[$];                   // LF appended when sent
    string       row_reply[$];                      // CR LF appended when checked
    logic [31:0] row_cards[$];                      // Card model bytes, card 0 on top
    logic [7:0]  row_port[$];
    logic [31:0] row_wdata[$];                      // Expected write bytes, card 0 on top
    int          row_kind[$];

    logic [7:0]  reply_q[$];
    logic [14:0] wr_log[$];                         // {card_sel, port_addr, data_out}
    logic [3:0]  rd_log[$];
    logic [31:0] cur_cards = '0;
    logic        prev_wr_n = 1'b1;
    logic        prev_rd_n = 1'b1;
    int          error_count = 0;
    int          bus_errors = 0;
    int          cycle_count = 0;
    int          cycle_limit = 0;

    pb_controller_top i_pb_controller_top (
        .clock      (clock),
        .arst_n     (arst_n),
        .rx_data    (rx_data),
        .rx_valid   (rx_valid),
        .data_in    (data_in),
        .bus        (bus),
        .lamp_reset (lamp_reset),
        .shifter_oe (shifter_oe),
        .tx_data    (tx_data),
        .tx_write   (tx_write)
    );

    bind phase_bus_sequencer pb_bus_checker i_pb_bus_checker (
        .clock  (clock),
        .arst_n (arst_n),
        .bus    (bus)
    );

    always #4 clock = ~clock;                       // Period 8

    ////////////////////////////////////////////////////////////////////////////
    // Card model, bus log and reply capture
    ////////////////////////////////////////////////////////////////////////////
    always @(posedge clock) begin
        data_in <= 8'h00;                           // Nobody drives when not reading
        for (int k = 0; k < `PB_NUM_CARDS; k++) begin
            if (bus.card_sel[k] && !bus.rd_n) begin
                data_in <= cur_cards[31 - 8 * k -: 8];
            end
        end
    end

    always @(negedge clock) begin
        if (tx_write) begin
            reply_q.push_back(tx_data);
        end
        if (bus.wr_n && !prev_wr_n) begin           // Rising wr_n, card latches here
            wr_log.push_back({bus.card_sel, bus.port_addr, bus.data_out});
        end
        if (bus.rd_n && !prev_rd_n) begin
            rd_log.push_back(bus.card_sel);
        end
        prev_wr_n = bus.wr_n;
        prev_rd_n = bus.rd_n;
    end

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Tasks
    ////////////////////////////////////////////////////////////////////////////
    task automatic check_value(input string test, input string what,
                               input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            error_count++;
            $display("ERROR %s %s: expected %h actual %h", test, what, exp, act);
        end
    endtask

    task automatic add_row(input string name, input string sentence, input string reply,
                           input logic [31:0] cards, input logic [7:0] port,
                           input logic [31:0] wdata, input int kind);
        row_name.push_back(name);
        row_sentence.push_back(sentence);
        row_reply.push_back(reply);
        row_cards.push_back(cards);
        row_port.push_back(port);
        row_wdata.push_back(wdata);
        row_kind.push_back(kind);
    endtask

    task automatic load_table();
        add_row("write_basic", "pb_i_write,051122AA3C", "Write 0x05",
                32'h0, 8'h05, 32'h1122AA3C, KIND_WRITE);
        add_row("read_basic", "pb_i__read,0300000000", "Read4 0xA53C0FE1",
                32'hA53C0FE1, 8'h03, 32'h0, KIND_READ);
        // Pairs fE aB cD 1g 9c, the g is not hex and reads as F
        add_row("write_mixed_case", "pb_i_write,fEaBcD1g9c", "Write 0xFE",
                32'h0, 8'hFE, 32'hABCD1F9C, KIND_WRITE);
        add_row("unknown_keyword", "pb_x_write,0112345678", "Failed 0x54",
                32'h0, 8'h00, 32'h0, KIND_REJECT);
        add_row("read_short", "pb_i__read,07", "Read4 0x00FF817E",
                32'h00FF817E, 8'h07, 32'h0, KIND_READ);
    endtask

    task automatic send_byte(input logic [7:0] b);
        @(posedge clock);
        rx_data  <= b;
        rx_valid <= 1'b1;
        @(posedge clock);
        rx_valid <= 1'b0;                           // Idle cycle between strobes
    endtask

    task automatic run_row(input int r);
        logic [7:0]  exp_q[$];
        logic [14:0] exp_entry;
        int          waited;
        int          exp_wr;
        int          exp_rd;
        reply_q.delete();
        wr_log.delete();
        rd_log.delete();
        cur_cards = row_cards[r];
        for (int i = 0; i < row_reply[r].len(); i++) begin
            exp_q.push_back(row_reply[r][i]);
        end
        exp_q.push_back(`PB_CHAR_CR);
        exp_q.push_back(`PB_CHAR_LF);
        for (int i = 0; i < row_sentence[r].len(); i++) begin
            send_byte(row_sentence[r][i]);
        end
        send_byte(`PB_CHAR_LF);
        waited = 0;
        while (reply_q.size() < exp_q.size() && waited < ROW_CYCLES) begin
            @(posedge clock);
            waited++;
        end
        repeat (4) @(posedge clock);                // Room for stray extra bytes
        check_value(row_name[r], "reply length", exp_q.size(), reply_q.size());
        for (int i = 0; i < exp_q.size() && i < reply_q.size(); i++) begin
            check_value(row_name[r], $sformatf("reply byte %0d", i), exp_q[i], reply_q[i]);
        end
        exp_wr = (row_kind[r] == KIND_WRITE) ? `PB_NUM_CARDS : 0;
        exp_rd = (row_kind[r] == KIND_READ) ? `PB_NUM_CARDS : 0;
        check_value(row_name[r], "write strobe count", exp_wr, wr_log.size());
        check_value(row_name[r], "read strobe count", exp_rd, rd_log.size());
        for (int k = 0; k < exp_wr && k < wr_log.size(); k++) begin
            exp_entry = {4'b0001 << k, row_port[r][2:0], row_wdata[r][31 - 8 * k -: 8]};
            check_value(row_name[r], $sformatf("write %0d sel/port/data", k),
                        exp_entry, wr_log[k]);
        end
        for (int k = 0; k < exp_rd && k < rd_log.size(); k++) begin
            check_value(row_name[r], $sformatf("read %0d card_sel", k),
                        4'b0001 << k, rd_log[k]);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////////////////////
    initial begin
        arst_n   = 1'b0;
        rx_data  = 8'h00;
        rx_valid = 1'b0;
        data_in  = 8'h00;
        load_table();
        cycle_limit = row_name.size() * ROW_CYCLES + `PB_INIT_CYCLES;
        repeat (15) @(posedge clock);
        @(negedge clock);
        check_value("power_up", "lamp_reset in reset", 1, lamp_reset);
        check_value("power_up", "shifter_oe in reset", 0, shifter_oe);
        check_value("power_up", "rd_n in reset", 1, bus.rd_n);
        check_value("power_up", "wr_n in reset", 1, bus.wr_n);
        check_value("power_up", "data_oe in reset", 0, bus.data_oe);
        check_value("power_up", "card_sel in reset", 0, bus.card_sel);
        @(posedge clock);
        arst_n <= 1'b1;                             // Release edge, hold counts from here
        repeat (`PB_INIT_CYCLES - 1) @(posedge clock);
        @(negedge clock);
        check_value("power_up", "lamp_reset before hold end", 1, lamp_reset);
        check_value("power_up", "shifter_oe before hold end", 0, shifter_oe);
        @(posedge clock);
        @(negedge clock);
        check_value("power_up", "lamp_reset after hold", 0, lamp_reset);
        check_value("power_up", "shifter_oe after hold", 1, shifter_oe);
        for (int r = 0; r < row_name.size(); r++) begin
            run_row(r);
        end
        bus_errors = i_pb_controller_top.i_phase_bus_sequencer.i_pb_bus_checker.fail_count;
        $display("Error counts: %0d testbench checks, %0d bus assertions",
                 error_count, bus_errors);
        if (error_count == 0 && bus_errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// File: src.f
+incdir+common
common/pb_pkg.sv
logic/command_parser.sv
phase_bus/phase_bus_sequencer.sv
logic/reply_formatter.sv
logic/pb_controller_top.sv
dv/pb_bus_checker.sv
dv/pb_controller_tb.sv

// File: Makefile
# Verilator build and run of the phase-bus controller testbench

SIM := obj_dir/Vpb_controller_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal \
		--top-module pb_controller_tb -f src.f

# Pass only when the simulation prints the pass line
run: compile
	@out="$$(./$(SIM) +verilator+error+limit+1000)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "PASS: all tests"

clean:
	rm -rf obj_dir
